/* lsu_defines.svh */
//////////////////////////////////////////////////
// Widths and limits shared by the LSU
// LSU_CNT_W must hold the value LSU_DEPTH
//////////////////////////////////////////////////

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and address width
`define LSU_XLEN  32

// Byte lanes on the data bus
`define LSU_BE_W  4

// Max outstanding bus transactions
`define LSU_DEPTH 2

// Outstanding counter width
`define LSU_CNT_W 2

`endif

/* lsu_pkg.sv */
//////////////////////////////////////////////////
// Types for the LSU, its bus and its tag queue
// Field order in the structs is part of the bus
//////////////////////////////////////////////////

`include "lsu_defines.svh"

package lsu_pkg;

  // Operation kind
  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

  // Access size, encoding matches the usual funct3 low bits
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Address phase of a split access
  typedef enum logic {
    ST_FIRST  = 1'b0,
    ST_SECOND = 1'b1
  } split_state_e;

  // Request from the core
  typedef struct packed {
    lsu_op_e              op;
    lsu_size_e            size;
    logic                 sext;    // Sign extend loaded data
    logic [`LSU_XLEN-1:0] base;
    logic [`LSU_XLEN-1:0] offset;
    logic [`LSU_XLEN-1:0] wdata;   // Store data, LSB aligned
  } lsu_req_t;

  // Bus address phase
  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
    logic                 we;
    logic [`LSU_BE_W-1:0] be;
    logic [`LSU_XLEN-1:0] wdata;   // Already rotated into lanes
  } bus_req_t;

  // Bus response phase
  typedef struct packed {
    logic [`LSU_XLEN-1:0] rdata;
  } bus_resp_t;

  // Per-transaction info for the read-data merge
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;   // Byte offset of the original address
    logic       first;    // First half of a split access
    logic       last;     // Completes the operation
  } lsu_tag_t;

endpackage

/* lsu_addr_phase.sv */
//////////////////////////////////////////////////
// Address phase. The core must hold req_i stable
// until req_ready_o, both halves of a split use it
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_addr_phase (
  input  logic                clk,
  input  logic                rst_n,

  // Core request
  input  logic                req_valid_i,
  input  lsu_pkg::lsu_req_t   req_i,
  output logic                req_ready_o,

  // From the tracker
  input  logic                room_i,

  // Bus address phase
  output logic                bus_valid_o,
  output lsu_pkg::bus_req_t   bus_req_o,
  input  logic                bus_ready_i,

  // To the tracker
  output logic                push_o,
  output lsu_pkg::lsu_tag_t   tag_o
);

  logic [`LSU_XLEN-1:0]   addr;         // base + offset
  logic [1:0]             offset;       // Byte offset in the word
  logic                   is_split;     // Access crosses a word boundary
  logic                   split_first;  // Issuing the first half of a split
  logic                   second;       // Issuing the second half
  logic [`LSU_BE_W-1:0]   size_mask;    // Lanes covered at offset 0
  logic [2*`LSU_BE_W-1:0] be_wide;      // Mask moved to the offset, spill in upper half
  logic [2*`LSU_XLEN-1:0] wdata_wide;
  lsu_pkg::split_state_e  state_q;

  assign addr   = req_i.base + req_i.offset;
  assign offset = addr[1:0];
  assign second = (state_q == lsu_pkg::ST_SECOND);

  // Word off alignment, or halfword in the top lane
  assign is_split = ((req_i.size == lsu_pkg::SIZE_WORD) && (offset != 2'b00)) ||
                    ((req_i.size == lsu_pkg::SIZE_HALF) && (offset == 2'b11));

  assign split_first = is_split && !second;

  //////////////////////////////////////////////////
  // Byte enables and lane rotation
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.size)
      lsu_pkg::SIZE_BYTE: size_mask = 4'b0001;
      lsu_pkg::SIZE_HALF: size_mask = 4'b0011;
      default:            size_mask = 4'b1111;
    endcase
  end

  // Lanes that fall past lane 3 belong to the second half
  assign be_wide = {{`LSU_BE_W{1'b0}}, size_mask} << offset;

  // Rotate left by whole bytes, upper word of the doubled data
  assign wdata_wide = {req_i.wdata, req_i.wdata} << {offset, 3'b000};

  //////////////////////////////////////////////////
  // Bus request and handshakes
  //////////////////////////////////////////////////

  assign bus_valid_o = req_valid_i && room_i;    // Hold off while tracker is full
  assign push_o      = bus_valid_o && bus_ready_i;

  // Core sees acceptance only with the last transfer
  assign req_ready_o = push_o && !split_first;

  always_comb begin
    bus_req_o.we    = (req_i.op == lsu_pkg::LSU_STORE);
    bus_req_o.wdata = wdata_wide[2*`LSU_XLEN-1:`LSU_XLEN];
    if (second) begin
      bus_req_o.addr = {addr[`LSU_XLEN-1:2], 2'b00} + `LSU_XLEN'(4); // Next word
      bus_req_o.be   = be_wide[2*`LSU_BE_W-1:`LSU_BE_W];            // Spilled lanes
    end else begin
      bus_req_o.addr = addr;
      bus_req_o.be   = be_wide[`LSU_BE_W-1:0];
    end
  end

  // Tag carried to the response side
  always_comb begin
    tag_o.size   = req_i.size;
    tag_o.sext   = req_i.sext;
    tag_o.we     = (req_i.op == lsu_pkg::LSU_STORE);
    tag_o.offset = offset;
    tag_o.first  = split_first;
    tag_o.last   = !split_first;   // Unsplit or second half
  end

  // Split tracking, advances on each accepted transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= lsu_pkg::ST_FIRST;
    end else if (push_o) begin
      state_q <= split_first ? lsu_pkg::ST_SECOND : lsu_pkg::ST_FIRST;
    end
  end

endmodule

/* lsu_txn_track.sv */
//////////////////////////////////////////////////
// In-order tag queue for outstanding transfers
// Expects one pop per push, never before it
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_txn_track (
  input  logic              clk,
  input  logic              rst_n,

  // Issue side
  input  logic              push_i,
  input  lsu_pkg::lsu_tag_t tag_i,

  // Response side
  input  logic              pop_i,

  output logic              room_o,
  output lsu_pkg::lsu_tag_t head_tag_o,
  output logic              busy_o
);

  localparam int PTR_W = (`LSU_DEPTH > 1) ? $clog2(`LSU_DEPTH) : 1;

  lsu_pkg::lsu_tag_t    tag_mem [`LSU_DEPTH];   // Tag storage
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [`LSU_CNT_W-1:0] cnt_q;                 // Outstanding transfers
  logic [`LSU_CNT_W-1:0] cnt_d;

  //////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////

  always_comb begin
    case ({push_i, pop_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;        // Idle, or push and pop cancel
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign room_o = (cnt_q < `LSU_CNT_W'(`LSU_DEPTH));
  assign busy_o = (cnt_q != '0);

  //////////////////////////////////////////////////
  // Tag queue
  //////////////////////////////////////////////////

  // Pointers wrap with the queue depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (pop_i)  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      tag_mem[wr_ptr_q] <= tag_i;
    end
  end

  assign head_tag_o = tag_mem[rd_ptr_q];   // Oldest outstanding transfer

endmodule

/* lsu_rdata_merge.sv */
//////////////////////////////////////////////////
// Response side. Output is combinational from the
// response, tag_i must be the head of the queue
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_rdata_merge (
  input  logic                 clk,
  input  logic                 rst_n,

  // Bus response and its tag
  input  logic                 rvalid_i,
  input  lsu_pkg::bus_resp_t   resp_i,
  input  lsu_pkg::lsu_tag_t    tag_i,

  // Result to the core
  output logic                 result_valid_o,
  output logic [`LSU_XLEN-1:0] result_rdata_o
);

  logic [`LSU_XLEN-1:0]   hold_q;       // Raw word of a split first half
  logic                   split_last;   // Second half of a split access
  logic [2*`LSU_XLEN-1:0] rdata_full;
  logic [2*`LSU_XLEN-1:0] rdata_shift;
  logic [`LSU_XLEN-1:0]   rdata_ext;

  // Keep the low word until its partner arrives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_q <= '0;
    end else if (rvalid_i && tag_i.first) begin
      hold_q <= resp_i.rdata;
    end
  end

  assign split_last = tag_i.last &&
                      (((tag_i.size == lsu_pkg::SIZE_WORD) && (tag_i.offset != 2'b00)) ||
                       ((tag_i.size == lsu_pkg::SIZE_HALF) && (tag_i.offset == 2'b11)));

  // New word on top, held word below, doubled word otherwise
  assign rdata_full  = split_last ? {resp_i.rdata, hold_q} : {resp_i.rdata, resp_i.rdata};
  assign rdata_shift = rdata_full >> {tag_i.offset, 3'b000};

  always_comb begin
    case (tag_i.size)
      lsu_pkg::SIZE_BYTE: rdata_ext = {{24{tag_i.sext && rdata_shift[7]}}, rdata_shift[7:0]};
      lsu_pkg::SIZE_HALF: rdata_ext = {{16{tag_i.sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:            rdata_ext = rdata_shift[`LSU_XLEN-1:0];
    endcase
  end

  // One strobe per operation, stores return zero
  assign result_valid_o = rvalid_i && tag_i.last;
  assign result_rdata_o = tag_i.we ? '0 : rdata_ext;

endmodule

/* lsu_top.sv */
//////////////////////////////////////////////////
// Load/store unit top. One operation at a time,
// bus responses in order, no back-pressure on them
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core request
  input  logic                 req_valid_i,
  input  lsu_pkg::lsu_req_t    req_i,
  output logic                 req_ready_o,

  // Data bus
  output logic                 bus_valid_o,
  output lsu_pkg::bus_req_t    bus_req_o,
  input  logic                 bus_ready_i,
  input  logic                 bus_rvalid_i,
  input  lsu_pkg::bus_resp_t   bus_resp_i,

  // Core result
  output logic                 result_valid_o,
  output logic [`LSU_XLEN-1:0] result_rdata_o,
  output logic                 busy_o
);

  logic              room;       // Tracker can take another transfer
  logic              push;       // Bus request accepted
  lsu_pkg::lsu_tag_t push_tag;
  lsu_pkg::lsu_tag_t head_tag;   // Tag of the oldest transfer

  //////////////////////////////////////////////////
  // Address phase and tracker
  //////////////////////////////////////////////////

  lsu_addr_phase addr_phase_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .room_i      (room),
    .bus_valid_o (bus_valid_o),
    .bus_req_o   (bus_req_o),
    .bus_ready_i (bus_ready_i),
    .push_o      (push),
    .tag_o       (push_tag)
  );

  lsu_txn_track txn_track_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (push),
    .tag_i      (push_tag),
    .pop_i      (bus_rvalid_i),   // Every response retires the head
    .room_o     (room),
    .head_tag_o (head_tag),
    .busy_o     (busy_o)
  );

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  lsu_rdata_merge rdata_merge_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .rvalid_i       (bus_rvalid_i),
    .resp_i         (bus_resp_i),
    .tag_i          (head_tag),
    .result_valid_o (result_valid_o),
    .result_rdata_o (result_rdata_o)
  );

endmodule

/* tb_clk_gen.sv */
//////////////////////////////////////////////////
// Clock and reset for the LSU testbench
// Reset is released 1 ns after the last reset edge
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;                         // Off the edge, like the stimulus
  end

endmodule

/* tb_mem_model.sv */
//////////////////////////////////////////////////
// Bus memory model, 1 KiB, address bits above 9 ignored
// Read data is captured at acceptance, responses in order
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mem_model (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               bus_valid_i,
  input  lsu_pkg::bus_req_t  bus_req_i,
  output logic               bus_ready_o,
  output logic               bus_rvalid_o,
  output lsu_pkg::bus_resp_t bus_resp_o,
  input  logic [3:0]         rnd_i,        // Grant bits [1:0], response bits [3:2]
  output logic [3:0]         pending_o     // Accepted but not yet answered
);

  logic [7:0]        mem [1024];
  logic [31:0]       rdata_q [16];         // Response data in issue order
  logic [3:0]        wr_ptr;
  logic [3:0]        rd_ptr;
  logic              take;
  logic              give;
  lsu_pkg::bus_req_t req;
  int                a;

  assign pending_o = wr_ptr - rd_ptr;

  initial begin
    for (a = 0; a < 1024; a++) mem[a] = 8'(a * 7) ^ 8'(a >> 8) ^ 8'h3c;
    wr_ptr       = '0;
    rd_ptr       = '0;
    bus_ready_o  = 1'b0;
    bus_rvalid_o = 1'b0;
    bus_resp_o   = '0;
    forever begin
      @(posedge clk);
      take = bus_valid_i && bus_ready_o;   // Handshakes seen at the edge
      give = bus_rvalid_o;
      req  = bus_req_i;
      #1;
      if (give) rd_ptr = rd_ptr + 4'd1;
      if (take) begin
        rdata_q[wr_ptr] = {mem[{req.addr[9:2], 2'd3}], mem[{req.addr[9:2], 2'd2}],
                           mem[{req.addr[9:2], 2'd1}], mem[{req.addr[9:2], 2'd0}]};
        for (a = 0; a < 4; a++) begin
          if (req.we && req.be[a]) mem[{req.addr[9:2], 2'(a)}] = req.wdata[8*a +: 8];
        end
        wr_ptr = wr_ptr + 4'd1;
      end
      // Grant and answer with 3/4 chance each
      bus_ready_o      = rst_n && (rnd_i[1:0] != 2'b00);
      bus_rvalid_o     = rst_n && (wr_ptr != rd_ptr) && (rnd_i[3:2] != 2'b00);
      bus_resp_o.rdata = bus_rvalid_o ? rdata_q[rd_ptr] : '0;
    end
  end

endmodule

/* tb_lsu.sv */
//////////////////////////////////////////////////
// LSU testbench with directed then random operations
// Checks sample at the falling edge
// Inputs move 1 ns after the rising edge
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "lsu_defines.svh"

module tb_lsu;

  localparam int DIRECTED_OPS = 45;
  localparam int RAND_OPS     = 48;
  localparam int OP_BUDGET    = 60;       // Worst case cycles per op under random stalls
  localparam int WATCHDOG_NS  = (16 + (DIRECTED_OPS + RAND_OPS) * OP_BUDGET) * 40;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  lsu_pkg::lsu_req_t    req;
  logic                 req_ready;
  logic                 bus_valid;
  lsu_pkg::bus_req_t    bus_req;
  logic                 bus_ready;
  logic                 bus_rvalid;
  lsu_pkg::bus_resp_t   bus_resp;
  logic                 result_valid;
  logic [`LSU_XLEN-1:0] result_rdata;
  logic                 busy;
  logic [3:0]           mem_rnd;
  logic [3:0]           mem_pending;

  logic [31:0]          lfsr_q = 32'h2fc925a9;
  logic [7:0]           ref_mem [1024];   // Predicted memory contents
  lsu_pkg::bus_req_t    exp_bus [4];      // Expected transfers of the current op
  logic [1:0]           xfer_cnt;         // Transfers accepted so far
  logic [31:0]          exp_data [256];   // Expected results in order
  logic [7:0]           exp_wr;
  logic [7:0]           exp_rd;
  logic                 started;          // First request driven
  logic                 got_result;

  tb_clk_gen clk_gen_inst (.clk(clk), .rst_n(rst_n));

  lsu_top lsu_top_inst (
    .clk(clk), .rst_n(rst_n),
    .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
    .bus_valid_o(bus_valid), .bus_req_o(bus_req), .bus_ready_i(bus_ready),
    .bus_rvalid_i(bus_rvalid), .bus_resp_i(bus_resp),
    .result_valid_o(result_valid), .result_rdata_o(result_rdata), .busy_o(busy)
  );

  tb_mem_model mem_model_inst (
    .clk(clk), .rst_n(rst_n), .bus_valid_i(bus_valid), .bus_req_i(bus_req),
    .bus_ready_o(bus_ready), .bus_rvalid_o(bus_rvalid), .bus_resp_o(bus_resp),
    .rnd_i(mem_rnd), .pending_o(mem_pending)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Galois form shifting right
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    int k;
    bits = '0;
    for (k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // One operation with expected values from the bus rules
  //////////////////////////////////////////////////

  task automatic run_op(input lsu_pkg::lsu_op_e op, input lsu_pkg::lsu_size_e size,
                        input logic sext, input logic [31:0] base, input logic [31:0] ofs,
                        input logic [31:0] wdata);
    logic [31:0]       addr;
    logic [31:0]       rot;
    logic [31:0]       ldval;
    logic [31:0]       gap;
    logic [1:0]        n_xfer;
    logic              pushed;
    logic              done;
    int                nbytes;
    int                lane;
    int                i;
    lsu_pkg::bus_req_t lo_xfer;
    lsu_pkg::bus_req_t hi_xfer;
    addr    = base + ofs;
    nbytes  = (size == lsu_pkg::SIZE_BYTE) ? 1 : (size == lsu_pkg::SIZE_HALF) ? 2 : 4;
    lo_xfer = '0;
    hi_xfer = '0;
    lane    = 0;
    for (i = 0; i < 4; i++) rot[8*((i + int'(addr[1:0])) % 4) +: 8] = wdata[8*i +: 8];
    for (i = 0; i < nbytes; i++) begin
      lane = i + int'(addr[1:0]);
      if (lane < 4) lo_xfer.be[lane] = 1'b1;
      else          hi_xfer.be[lane-4] = 1'b1;                 // Spills into next word
    end
    n_xfer        = (lane > 3) ? 2'd2 : 2'd1;
    lo_xfer.addr  = addr;
    hi_xfer.addr  = {addr[31:2], 2'b00} + 32'd4;
    lo_xfer.we    = (op == lsu_pkg::LSU_STORE);
    hi_xfer.we    = lo_xfer.we;
    lo_xfer.wdata = rot;
    hi_xfer.wdata = rot;
    ldval = '0;
    for (i = 0; i < nbytes; i++) ldval[8*i +: 8] = ref_mem[addr[9:0] + 10'(i)];
    if (sext && size == lsu_pkg::SIZE_BYTE && ldval[7])  ldval[31:8]  = '1;
    if (sext && size == lsu_pkg::SIZE_HALF && ldval[15]) ldval[31:16] = '1;
    if (op == lsu_pkg::LSU_STORE) begin
      for (i = 0; i < nbytes; i++) ref_mem[addr[9:0] + 10'(i)] = wdata[8*i +: 8];
      ldval = '0;                                              // Stores return zero
    end
    exp_bus[0]       = lo_xfer;
    exp_bus[1]       = hi_xfer;
    xfer_cnt         = '0;
    exp_data[exp_wr] = ldval;
    exp_wr           = exp_wr + 8'd1;
    req.op     = op;
    req.size   = size;
    req.sext   = sext;
    req.base   = base;
    req.offset = ofs;
    req.wdata  = wdata;
    req_valid  = 1'b1;
    started    = 1'b1;
    done       = 1'b0;
    while (!done) begin
      @(posedge clk);
      pushed = bus_valid && bus_ready;
      done   = req_ready;
      #1;
      if (pushed) xfer_cnt = xfer_cnt + 2'd1;
    end
    req_valid = 1'b0;
    assert (xfer_cnt == n_xfer)
      else stop_on_error($sformatf("MISMATCH at %0t: %0d bus transfers for addr %h, expected %0d",
                                   $time, xfer_cnt, addr, n_xfer));
    take_bits(1, gap);
    if (gap[0]) begin                                          // Idle cycle now and then
      @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  assert property (@(negedge clk) !started |-> !bus_valid && !req_ready && !result_valid && !busy)
    else stop_on_error($sformatf("MISMATCH at %0t: LSU active before the first request", $time));

  assert property (@(negedge clk) disable iff (!rst_n)
    bus_valid |-> (bus_req.addr == exp_bus[xfer_cnt].addr) && (bus_req.be == exp_bus[xfer_cnt].be)
      && (bus_req.we == exp_bus[xfer_cnt].we)
      && (!bus_req.we || bus_req.wdata == exp_bus[xfer_cnt].wdata))
    else stop_on_error($sformatf("MISMATCH at %0t: bus addr %h be %b wdata %h, expected %h %b %h",
      $time, bus_req.addr, bus_req.be, bus_req.wdata, exp_bus[xfer_cnt].addr,
      exp_bus[xfer_cnt].be, exp_bus[xfer_cnt].wdata));

  assert property (@(negedge clk) disable iff (!rst_n)
    (bus_valid && !bus_ready) |=> (bus_valid && $stable(bus_req)))
    else stop_on_error($sformatf("MISMATCH at %0t: bus request changed while stalled", $time));

  assert property (@(negedge clk) disable iff (!rst_n)
    result_valid |-> (exp_rd != exp_wr) && (result_rdata == exp_data[exp_rd]))
    else stop_on_error($sformatf("MISMATCH at %0t: result %h, expected %h (%0d of %0d done)",
      $time, result_rdata, exp_data[exp_rd], exp_rd, exp_wr));

  assert property (@(negedge clk) disable iff (!rst_n)
    (mem_pending <= 4'(`LSU_DEPTH)) && ((mem_pending == 4'd0) || busy))
    else stop_on_error($sformatf("MISMATCH at %0t: %0d outstanding, busy %b",
      $time, mem_pending, busy));

  //////////////////////////////////////////////////
  // Random bits, result counter, watchdog
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] bits;
    mem_rnd = 4'd0;
    forever begin
      @(negedge clk);
      take_bits(4, bits);
      mem_rnd = bits[3:0];
    end
  end

  initial begin
    exp_rd = '0;
    forever begin
      @(posedge clk);
      got_result = result_valid;
      #1;
      if (got_result) exp_rd = exp_rd + 8'd1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    stop_on_error("Watchdog expired before all operations completed");
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int          i;
    logic [31:0] bits;
    logic [31:0] wd;
    logic [1:0]  sz;
    req_valid = 1'b0;
    req       = '0;
    started   = 1'b0;
    exp_wr    = '0;
    xfer_cnt  = '0;
    for (i = 0; i < 4; i++) exp_bus[i] = '0;
    for (i = 0; i < 1024; i++) ref_mem[i] = 8'(i * 7) ^ 8'(i >> 8) ^ 8'h3c;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    // Aligned store then load through base plus offset
    run_op(lsu_pkg::LSU_STORE, lsu_pkg::SIZE_WORD, 1'b0, 32'h1f0, 32'h10, 32'h8f7e_c1a5);
    run_op(lsu_pkg::LSU_LOAD, lsu_pkg::SIZE_WORD, 1'b0, 32'h200, 32'h0, 32'h0);
    run_op(lsu_pkg::LSU_STORE, lsu_pkg::SIZE_WORD, 1'b0, 32'h204, 32'h0, 32'h1b93_e46d);
    for (i = 0; i < 4; i++) begin        // Every offset with both extensions
      run_op(lsu_pkg::LSU_LOAD, lsu_pkg::SIZE_BYTE, 1'b0, 32'h200, 32'(i), 32'h0);
      run_op(lsu_pkg::LSU_LOAD, lsu_pkg::SIZE_BYTE, 1'b1, 32'h200, 32'(i), 32'h0);
      run_op(lsu_pkg::LSU_LOAD, lsu_pkg::SIZE_HALF, 1'b0, 32'h200, 32'(i), 32'h0);
      run_op(lsu_pkg::LSU_LOAD, lsu_pkg::SIZE_HALF, 1'b1, 32'h200, 32'(i), 32'h0);
    end
    for (i = 1; i < 4; i++) run_op(lsu_pkg::LSU_LOAD, lsu_pkg::SIZE_WORD, 1'b0, 32'h200,
                                   32'(i), 32'h0);
    for (i = 0; i < 4; i++) begin        // Narrow stores where a half at offset 3 splits
      run_op(lsu_pkg::LSU_STORE, lsu_pkg::SIZE_BYTE, 1'b0, 32'h280, 32'(i), 32'ha0 + 32'(i));
      run_op(lsu_pkg::LSU_STORE, lsu_pkg::SIZE_HALF, 1'b0, 32'h284, 32'(i), 32'hc3b0 + 32'(i));
    end
    for (i = 1; i < 4; i++) run_op(lsu_pkg::LSU_STORE, lsu_pkg::SIZE_WORD, 1'b0, 32'h290,
                                   32'(5 * i), 32'h9a5b_3c10 + 32'(i));
    for (i = 0; i < 9; i++) run_op(lsu_pkg::LSU_LOAD, lsu_pkg::SIZE_WORD, 1'b0, 32'h280,
                                   32'(4 * i), 32'h0);
    for (i = 1; i < 4; i++) run_op(lsu_pkg::LSU_LOAD, lsu_pkg::SIZE_WORD, 1'b0, 32'h290,
                                   32'(5 * i), 32'h0);
    // Random mix in a small window so loads hit earlier stores
    for (i = 0; i < RAND_OPS; i++) begin
      take_bits(12, bits);
      take_bits(32, wd);
      sz = (bits[1:0] == 2'b11) ? 2'b10 : bits[1:0];
      run_op(lsu_pkg::lsu_op_e'(bits[2]), lsu_pkg::lsu_size_e'(sz), bits[3],
             32'h300 + 32'(bits[9:4]), 32'(bits[11:10]), wd);
    end
    // Drain at the falling edge where counters and the model are settled
    @(negedge clk);
    while ((exp_rd != exp_wr) || busy) begin
      @(negedge clk);
    end
    if (mem_pending == 4'd0) begin
      $display("sim passed");
      $finish;
    end else begin
      stop_on_error("Bus still had outstanding requests after the last result");
    end
  end

endmodule

/* list.f */
+incdir+.
lsu_pkg.sv
lsu_addr_phase.sv
lsu_txn_track.sv
lsu_rdata_merge.sv
lsu_top.sv
tb_clk_gen.sv
tb_mem_model.sv
tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# Build the LSU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_lsu -f list.f -o sim_lsu

# A fatal stop returns nonzero and ends the script here
out=$(./obj_dir/sim_lsu)
echo "$out"

# Pass only if the testbench reported it
echo "$out" | grep -q "sim passed"
